// ==== verification/maindec_tests.txt ====
# columns: instr word (hex), expected ctrl (20-bit hex), expected illinstr (bit)
# text after the third column is a note for the reader
# memory and arithmetic
00012083 012C1 0  lw x1, 0(x2)
FFC4A303 012C1 0  lw, negative offset
0080A403 012C1 0  lw x8, 8(x1)
7FF5A883 012C1 0  lw, max offset
00002003 012C1 0  lw x0, 0(x0)
0020A023 00A82 0  sw x2, 0(x1)
FE112E23 00A82 0  sw x1, -4(x2)
00B52223 00A82 0  sw x11, 4(x10)
7E0FAFA3 00A82 0  sw, high offset bits
0000A023 00A82 0  sw x0, 0(x1)
00000013 002D1 0  nop
FFF00093 002D1 0  addi x1, x0, -1
00A58593 002D1 0  addi x11, x11, 10
7FF28293 002D1 0  addi x5, x5, 2047
80010113 002D1 0  addi sp, sp, -2048
002081B3 00250 0  add x3, x1, x2
00000033 00250 0  add x0, x0, x0
01FF8FB3 00250 0  add x31, x31, x31
00C58533 00250 0  add x10, x11, x12
40208133 00250 0  sub x2, x1, x2
40000033 00250 0  sub x0, x0, x0
41FF8FB3 00250 0  sub x31, x31, x31
40B50533 00250 0  sub x10, x10, x11
# control flow
00208463 0010B 0  beq x1, x2, 8
FE000EE3 0010B 0  beq, backward
7E1F8FE3 0010B 0  beq, far forward
00000063 0010B 0  beq x0, x0, 0
00209463 0030B 0  bne x1, x2, 8
FE0018E3 0030B 0  bne, backward
7E1F9FE3 0030B 0  bne, far forward
00001063 0030B 0  bne x0, x0, 0
00008067 002E1 0  ret
000080E7 002E1 0  jalr x1, 0(x1)
FFC28367 002E1 0  jalr x6, -4(x5)
00000067 002E1 0  jalr x0, 0(x0)
# csr access
30029073 102C1 0  csrrw x0, mstatus, x5
34011173 102C1 0  csrrw x2, mscratch, x2
300022F3 122C1 0  csrrs x5, mstatus, x0
3420A073 122C1 0  csrrs x0, mcause, x1
3000B073 142C1 0  csrrc x0, mstatus, x1
30403373 142C1 0  csrrc x6, mie, x0
3052D073 182C1 0  csrrwi x0, mtvec, 5
34045073 182C1 0  csrrwi x0, mscratch, 8
30046073 1A2C1 0  csrrsi x0, mstatus, 8
300FE2F3 1A2C1 0  csrrsi x5, mstatus, 31
30047073 1C2C1 0  csrrci x0, mstatus, 8
3001F373 1C2C1 0  csrrci x6, mstatus, 3
# mret, lui, auipc
30200073 20281 0  mret
302000F3 20281 0  mret, rd bits set
31000073 20281 0  mret, rs2 bits differ
123450B7 802C4 0  lui x1, 0x12345
00000037 802C4 0  lui x0, 0
FFFFF2B7 802C4 0  lui x5, 0xfffff
80000537 802C4 0  lui x10, 0x80000
00000097 402C4 0  auipc x1, 0
12345117 402C4 0  auipc x2, 0x12345
FFFFF197 402C4 0  auipc x3, 0xfffff
00000017 402C4 0  auipc x0, 0
# illegal words
00000000 00000 1  all zero
FFFFFFFF 00000 1  all ones
0000006F 00000 1  jal
0000000F 00000 1  fence
00001013 00000 1  slli
00004013 00000 1  xori
02208133 00000 1  add opcode, funct7 0000001
20000033 00000 1  add opcode, funct7 0010000
002091B3 00000 1  sll
40001033 00000 1  sub funct7 with funct3 001
0020C463 00000 1  blt
00004063 00000 1  branch funct3 100
00005063 00000 1  bge
00000073 00000 1  ecall
00100073 00000 1  ebreak
10500073 00000 1  wfi
00004073 00000 1  system funct3 100
00002067 00000 1  jalr opcode, funct3 010
0000A0E7 00000 1  jalr opcode, funct3 010, rs1 odd
0000007F 00000 1  opcode 1111111
00000001 00000 1  compressed style word
0000202F 00000 1  amo opcode

// ==== tb.f ====
hdl/cpu6_pkg.sv
hdl/cpu6_instr_classify.sv
hdl/cpu6_control_table.sv
hdl/cpu6_maindec.sv
verification/cpu6_maindec_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu6_maindec testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns -f tb.f \
   --top-module cpu6_maindec_tb -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/Vcpu6_maindec_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
   exit 1
fi
exit 0

// ==== verification/cpu6_maindec_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu6_maindec_tb;
   import cpu6_pkg::*;

   localparam int    MAX_LINES = 1000;                             // guard on the reader
   localparam string TEST_FILE = "verification/maindec_tests.txt"; // from the project root

   logic          clk;      // only paces the vectors
   instr_t        instr;    // word under test
   maindec_ctrl_t ctrl;     // dut control bundle
   logic          illinstr; // dut illegal flag

   int ctrl_errors;  // bundle mismatches
   int ill_errors;   // flag mismatches
   int file_errors;  // open, format and runaway problems
   int vectors;      // words checked
   int legal_seen;   // vectors expected legal
   int illegal_seen; // vectors expected illegal

   cpu6_maindec cpu6_maindec_inst (
      .instr    (instr),
      .ctrl     (ctrl),
      .illinstr (illinstr)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk; // 10 ns period

   // bundle split into named fields
   function automatic string ctrl_fields(input maindec_ctrl_t c);
      string s;
      s = $sformatf("lui=%b auipc=%b mret=%b csr=%b csr_src=%b csr_wsc=%b ",
                    c.lui, c.auipc, c.mret, c.csr, c.csr_src, c.csr_wsc);
      s = {s, $sformatf("memtoreg=%b memwrite=%b branchtype=%b alusrc=%b ",
                        c.memtoreg, c.memwrite, c.branchtype, c.alusrc)};
      s = {s, $sformatf("regwrite=%b jump=%b aluop=%b immtype=%0d",
                        c.regwrite, c.jump, c.aluop, c.immtype)};
      return s;
   endfunction

   task automatic check_ctrl(input instr_t word, input maindec_ctrl_t expected,
                             input maindec_ctrl_t actual);
      if (actual !== expected) begin
         ctrl_errors++;
         $display("ERROR %0t ns ctrl for instr %h expected %h got %h",
                  $time, word, expected, actual);
         $display("   expected %s", ctrl_fields(expected)); // where the rows differ
         $display("   actual   %s", ctrl_fields(actual));
      end
   endtask

   task automatic check_illegal(input instr_t word, input logic expected,
                                input logic actual);
      if (actual !== expected) begin
         ill_errors++;
         $display("ERROR %0t ns illinstr for instr %h expected %b got %b",
                  $time, word, expected, actual);
      end
   endtask

   // one word per clock, compared on the following rising edge
   task automatic run_vector(input instr_t word, input maindec_ctrl_t exp_ctrl,
                             input logic exp_ill);
      #1;
      instr = word;
      @(posedge clk); // outputs long settled here
      check_ctrl(word, exp_ctrl, ctrl);
      check_illegal(word, exp_ill, illinstr);
      vectors++;
      if (exp_ill) begin
         illegal_seen++;
      end else begin
         legal_seen++;
      end
   endtask

   task automatic read_vectors();
      int          fd;
      int          rc;
      int          lines;
      int          fields;
      string       line;
      logic [31:0] word;
      logic [19:0] exp_bits;
      logic        exp_ill;
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         $display("could not open the vector file %s", TEST_FILE);
         file_errors++;
         return;
      end
      lines = 0;
      while (!$feof(fd) && lines < MAX_LINES) begin
         rc = $fgets(line, fd);
         lines++;
         if (rc == 0) begin
            continue; // nothing left
         end
         if (line.len() == 0 || line[0] == "#") begin
            continue; // column header and group notes
         end
         fields = $sscanf(line, "%h %h %b", word, exp_bits, exp_ill);
         if (fields == 3) begin
            run_vector(word, maindec_ctrl_t'(exp_bits), exp_ill);
         end else if (fields > 0) begin
            $display("line %0d of the vector file has too few columns: %s", lines, line);
            file_errors++;
         end
      end
      if (!$feof(fd)) begin
         $display("vector file not at its end after %0d lines, reading stopped", MAX_LINES);
         file_errors++;
      end
      $fclose(fd);
   endtask

   initial begin
      instr        = '0; // only dut input
      ctrl_errors  = 0;
      ill_errors   = 0;
      file_errors  = 0;
      vectors      = 0;
      legal_seen   = 0;
      illegal_seen = 0;
      @(posedge clk); // first vector starts on an edge
      read_vectors();
      if (vectors == 0) begin
         $display("no vectors were applied, the vector file holds no usable line");
         file_errors++;
      end
      $display("errors ctrl %0d illinstr %0d file %0d over %0d vectors (%0d legal, %0d illegal)",
               ctrl_errors, ill_errors, file_errors, vectors, legal_seen, illegal_seen);
      if (ctrl_errors + ill_errors + file_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/cpu6_maindec.sv ====
`timescale 1ns/1ns
`default_nettype none

// main decoder in two steps
// classify the word first, then look the kind up in the control table
module cpu6_maindec (
   input  wire cpu6_pkg::instr_t        instr,
   output cpu6_pkg::maindec_ctrl_t      ctrl,
   output logic                         illinstr
);
   import cpu6_pkg::*;

   instr_kind_e kind; // classifier result, KIND_NONE on illegal words

   // opcode/funct3/funct7 match
   cpu6_instr_classify cpu6_instr_classify_inst (
      .instr    (instr),
      .kind     (kind),
      .illinstr (illinstr)  // high when kind is KIND_NONE
   );

   // kind to 20-bit control bundle
   cpu6_control_table cpu6_control_table_inst (
      .kind (kind),
      .ctrl (ctrl)          // all zero when illegal
   );

endmodule

`default_nettype wire

// ==== hdl/cpu6_control_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu6_control_table (
   input  wire cpu6_pkg::instr_kind_e   kind,
   output cpu6_pkg::maindec_ctrl_t      ctrl
);
   import cpu6_pkg::*;

   always_comb begin
      ctrl = '0; // illegal row, branchtype stays BR_NONE
      if (kind != KIND_NONE) begin
         ctrl.branchtype = BR_NOBRANCH; // legal words default to no branch
      end
      case (kind)
         KIND_LW: begin
            ctrl.memtoreg = 1'b1;           // rd from memory
            ctrl.alusrc   = ALUSRC_IMM;     // base + offset
            ctrl.regwrite = 1'b1;
            ctrl.aluop    = ALUOP_LWSWJALR;
            ctrl.immtype  = IMM_I;
         end
         KIND_SW: begin
            ctrl.memwrite = 1'b1;
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.aluop    = ALUOP_LWSWJALR;
            ctrl.immtype  = IMM_S;          // split offset
         end
         KIND_ADDI: begin
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;
            ctrl.aluop    = ALUOP_ARITH;
            ctrl.immtype  = IMM_I;
         end
         KIND_ADD, KIND_SUB: begin
            ctrl.alusrc   = ALUSRC_RS2;     // register operand
            ctrl.regwrite = 1'b1;
            ctrl.aluop    = ALUOP_ARITH;    // alu decoder splits add/sub
            ctrl.immtype  = IMM_R;
         end
         KIND_BEQ: begin
            ctrl.branchtype = BR_BEQ;
            ctrl.alusrc     = ALUSRC_RS2;   // compare rs1 with rs2
            ctrl.aluop      = ALUOP_BRANCH;
            ctrl.immtype    = IMM_B;
         end
         KIND_BNE: begin
            ctrl.branchtype = BR_BNE;
            ctrl.alusrc     = ALUSRC_RS2;
            ctrl.aluop      = ALUOP_BRANCH;
            ctrl.immtype    = IMM_B;
         end
         KIND_JALR: begin
            ctrl.alusrc   = ALUSRC_IMM;     // target rs1 + imm
            ctrl.regwrite = 1'b1;           // link to rd
            ctrl.jump     = 1'b1;
            ctrl.aluop    = ALUOP_LWSWJALR;
            ctrl.immtype  = IMM_I;
         end
         // csr rows leave aluop at 00 since the alu is unused
         KIND_CSRRW: begin
            ctrl.csr      = 1'b1;
            ctrl.csr_wsc  = CSR_W;
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;           // old csr value to rd
            ctrl.immtype  = IMM_I;          // csr address in imm field
         end
         KIND_CSRRS: begin
            ctrl.csr      = 1'b1;
            ctrl.csr_wsc  = CSR_S;
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;
            ctrl.immtype  = IMM_I;
         end
         KIND_CSRRC: begin
            ctrl.csr      = 1'b1;
            ctrl.csr_wsc  = CSR_C;
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;
            ctrl.immtype  = IMM_I;
         end
         KIND_CSRRWI: begin
            ctrl.csr      = 1'b1;
            ctrl.csr_src  = CSR_SRC_UIMM;   // rs1 field as 5-bit uimm
            ctrl.csr_wsc  = CSR_W;
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;
            ctrl.immtype  = IMM_I;
         end
         KIND_CSRRSI: begin
            ctrl.csr      = 1'b1;
            ctrl.csr_src  = CSR_SRC_UIMM;
            ctrl.csr_wsc  = CSR_S;
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;
            ctrl.immtype  = IMM_I;
         end
         KIND_CSRRCI: begin
            ctrl.csr      = 1'b1;
            ctrl.csr_src  = CSR_SRC_UIMM;
            ctrl.csr_wsc  = CSR_C;
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;
            ctrl.immtype  = IMM_I;
         end
         KIND_MRET: begin
            ctrl.mret    = 1'b1;            // return from trap
            ctrl.alusrc  = ALUSRC_IMM;
            ctrl.immtype = IMM_I;
         end
         KIND_LUI: begin
            ctrl.lui      = 1'b1;
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;
            ctrl.aluop    = ALUOP_LWSWJALR;
            ctrl.immtype  = IMM_U;
         end
         KIND_AUIPC: begin
            ctrl.auipc    = 1'b1;           // pc + upper imm
            ctrl.alusrc   = ALUSRC_IMM;
            ctrl.regwrite = 1'b1;
            ctrl.aluop    = ALUOP_LWSWJALR;
            ctrl.immtype  = IMM_U;
         end
         default: ; // KIND_NONE keeps the zero row
      endcase
   end

   always_comb begin
      a_wsc_legal: assert final (ctrl.csr_wsc != 2'b11)
         else $error("ctrl csr_wsc 11 for kind %s", kind.name());
      a_jump_no_store: assert final (!(ctrl.jump && ctrl.memwrite))
         else $error("ctrl jump with memwrite for kind %s", kind.name());
      a_branch_aluop: assert final ((ctrl.branchtype inside {BR_NONE, BR_NOBRANCH})
                                    || (ctrl.aluop == ALUOP_BRANCH))
         else $error("ctrl branch without compare aluop for kind %s", kind.name());
   end

endmodule

`default_nettype wire

// ==== hdl/cpu6_instr_classify.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu6_instr_classify (
   input  wire cpu6_pkg::instr_t   instr,
   output cpu6_pkg::instr_kind_e   kind,
   output logic                    illinstr
);
   import cpu6_pkg::*;

   wire opcode_t op     = instr[6:0];   // major opcode
   wire funct3_t funct3 = instr[14:12]; // minor opcode
   wire funct7_t funct7 = instr[31:25]; // r-type and system qualifier

   // opcodes that need funct3 or funct7 to finish the match
   wire op_imm    = (op == OP_IMM);
   wire op_reg    = (op == OP_REG);
   wire op_branch = (op == OP_BRANCH);
   wire op_system = (op == OP_SYSTEM);

   wire f3_000 = (funct3 == 3'b000);
   wire f3_001 = (funct3 == 3'b001);
   wire f3_010 = (funct3 == 3'b010);
   wire f3_011 = (funct3 == 3'b011);
   wire f3_101 = (funct3 == 3'b101);
   wire f3_110 = (funct3 == 3'b110);
   wire f3_111 = (funct3 == 3'b111);

   wire f7_base = (funct7 == F7_BASE);
   wire f7_alt  = (funct7 == F7_ALT);
   wire f7_mret = (funct7 == F7_MRET);

   wire is_lw     = (op == OP_LOAD);   // funct3 not checked
   wire is_sw     = (op == OP_STORE);  // funct3 not checked
   wire is_addi   = op_imm & f3_000;
   wire is_add    = op_reg & f3_000 & f7_base;
   wire is_sub    = op_reg & f3_000 & f7_alt;
   wire is_beq    = op_branch & f3_000;
   wire is_bne    = op_branch & f3_001;
   wire is_jalr   = (op == OP_JALR) & f3_000;
   wire is_csrrw  = op_system & f3_001;
   wire is_csrrs  = op_system & f3_010;
   wire is_csrrc  = op_system & f3_011;
   wire is_csrrwi = op_system & f3_101; // uimm forms set funct3[2]
   wire is_csrrsi = op_system & f3_110;
   wire is_csrrci = op_system & f3_111;
   wire is_mret   = op_system & f3_000 & f7_mret;
   wire is_lui    = (op == OP_LUI);
   wire is_auipc  = (op == OP_AUIPC);

   wire [16:0] hits = {
      is_lw, is_sw, is_addi, is_add, is_sub, is_beq, is_bne, is_jalr,
      is_csrrw, is_csrrs, is_csrrc, is_csrrwi, is_csrrsi, is_csrrci,
      is_mret, is_lui, is_auipc
   }; // all pattern matches, for the overlap check

   // patterns are disjoint so the order of the ifs does not matter
   always_comb begin
      kind = KIND_NONE; // fall through to illegal
      if (is_lw)     kind = KIND_LW;
      if (is_sw)     kind = KIND_SW;
      if (is_addi)   kind = KIND_ADDI;
      if (is_add)    kind = KIND_ADD;
      if (is_sub)    kind = KIND_SUB;
      if (is_beq)    kind = KIND_BEQ;
      if (is_bne)    kind = KIND_BNE;
      if (is_jalr)   kind = KIND_JALR;
      if (is_csrrw)  kind = KIND_CSRRW;
      if (is_csrrs)  kind = KIND_CSRRS;
      if (is_csrrc)  kind = KIND_CSRRC;
      if (is_csrrwi) kind = KIND_CSRRWI;
      if (is_csrrsi) kind = KIND_CSRRSI;
      if (is_csrrci) kind = KIND_CSRRCI;
      if (is_mret)   kind = KIND_MRET;
      if (is_lui)    kind = KIND_LUI;
      if (is_auipc)  kind = KIND_AUIPC;
   end

   assign illinstr = (kind == KIND_NONE); // no supported pattern hit

   // a second hit would be silently dropped by the if chain above
   always_comb begin
      a_single_match: assert final ($onehot0(hits))
         else $error("classify %h hits several patterns %b", instr, hits);
   end

endmodule

`default_nettype wire

// ==== hdl/cpu6_pkg.sv ====
`default_nettype none

package cpu6_pkg;

   // instruction word and the fields the decoder looks at
   typedef logic [31:0] instr_t;   // one rv32 word
   typedef logic [6:0]  opcode_t;  // instr[6:0]
   typedef logic [2:0]  funct3_t;  // instr[14:12]
   typedef logic [6:0]  funct7_t;  // instr[31:25]

   localparam opcode_t OP_LOAD   = 7'b0000011; // lw and friends
   localparam opcode_t OP_STORE  = 7'b0100011; // sw and friends
   localparam opcode_t OP_IMM    = 7'b0010011; // i-type arithmetic
   localparam opcode_t OP_REG    = 7'b0110011; // r-type arithmetic
   localparam opcode_t OP_BRANCH = 7'b1100011; // conditional branches
   localparam opcode_t OP_JALR   = 7'b1100111; // indirect jump
   localparam opcode_t OP_SYSTEM = 7'b1110011; // csr access and mret
   localparam opcode_t OP_LUI    = 7'b0110111; // upper immediate
   localparam opcode_t OP_AUIPC  = 7'b0010111; // pc relative upper imm

   localparam funct7_t F7_BASE = 7'b0000000; // add
   localparam funct7_t F7_ALT  = 7'b0100000; // sub
   localparam funct7_t F7_MRET = 7'b0011000; // mret qualifier

   // output of the classify stage, index into the control table
   typedef enum logic [4:0] {
      KIND_NONE,   // nothing matched
      KIND_LW,
      KIND_SW,
      KIND_ADDI,
      KIND_ADD,
      KIND_SUB,
      KIND_BEQ,
      KIND_BNE,
      KIND_JALR,
      KIND_CSRRW,
      KIND_CSRRS,
      KIND_CSRRC,
      KIND_CSRRWI,
      KIND_CSRRSI,
      KIND_CSRRCI,
      KIND_MRET,
      KIND_LUI,
      KIND_AUIPC
   } instr_kind_e;

   typedef enum logic [2:0] {
      BR_NONE     = 3'b000, // only on illegal words
      BR_BEQ      = 3'b001,
      BR_NOBRANCH = 3'b010, // every legal non-branch
      BR_BNE      = 3'b011
   } branchtype_e;

   typedef enum logic [1:0] {
      ALUOP_LWSWJALR = 2'b00, // address add
      ALUOP_BRANCH   = 2'b01, // compare
      ALUOP_ARITH    = 2'b10  // funct3/funct7 decides
   } aluop_e;

   typedef enum logic [2:0] {
      IMM_R = 3'd0, // no immediate
      IMM_I = 3'd1,
      IMM_S = 3'd2,
      IMM_B = 3'd3,
      IMM_U = 3'd4
   } immtype_e;

   typedef enum logic [1:0] {
      CSR_W = 2'b00, // write
      CSR_S = 2'b01, // set bits
      CSR_C = 2'b10  // clear bits
   } csr_wsc_e;

   typedef enum logic {
      ALUSRC_RS2 = 1'b0,
      ALUSRC_IMM = 1'b1
   } alusrc_e;

   typedef enum logic {
      CSR_SRC_RS1  = 1'b0, // register operand
      CSR_SRC_UIMM = 1'b1  // rs1 index used as zero-extended uimm
   } csr_src_e;

   // 20-bit control bundle, msb first
   typedef struct packed {
      logic        lui;        // [19]
      logic        auipc;      // [18]
      logic        mret;       // [17]
      logic        csr;        // [16] csr access enable
      csr_src_e    csr_src;    // [15]
      csr_wsc_e    csr_wsc;    // [14:13]
      logic        memtoreg;   // [12]
      logic        memwrite;   // [11]
      branchtype_e branchtype; // [10:8]
      alusrc_e     alusrc;     // [7]
      logic        regwrite;   // [6]
      logic        jump;       // [5]
      aluop_e      aluop;      // [4:3]
      immtype_e    immtype;    // [2:0]
   } maindec_ctrl_t;

endpackage

`default_nettype wire
